//--- include/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// object boxes in pixels
`define DRAGON_W 11
`define DRAGON_H 48
`define SHOT_W 8
`define SHOT_H 4

// speeds in 1/64 pixel per frame
`define DRAGON_X_SPEED -120
`define DRAGON_Y_SPEED 70
`define SHOT_SPEED 256

// entry points
`define DRAGON_START_X 680
`define DRAGON_START_Y 60
`define SHOT_START_X 16

// vertical bounce band and the column where the dragon leaves
`define DRAGON_TOP_ROW 20
`define DRAGON_BOTTOM_ROW 180
`define DRAGON_EXIT_X -50
`define SCREEN_RIGHT 640

// frames of wait before the first entry
`define DRAGON_FIRST_WAIT 3

// raster totals including blanking
`define FRAME_COLS 800
`define FRAME_ROWS 525

`endif

//--- logic/gamePkg.sv
package gamePkg;

	// screen position in whole pixels
	typedef logic signed [10:0] coord_t;

	// sub-pixel position, 6 fraction bits below the coord_t bits
	typedef logic signed [16:0] fixed_t;

	// velocity in 1/64 pixel per frame
	typedef logic signed [11:0] speed_t;

	localparam int FRAC_BITS = 6;

	// drop the fraction, keep the integer pixel
	function automatic coord_t fixedToCoord(input fixed_t pos);
		coord_t whole;
		whole = pos[16:FRAC_BITS];
		return whole;
	endfunction

	// widen a velocity so it adds cleanly to a position
	function automatic fixed_t speedToFixed(input speed_t spd);
		fixed_t step;
		step = fixed_t'(spd);
		return step;
	endfunction

endpackage

//--- logic/frameTimer.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module frameTimer #(
	parameter int frameCols = `FRAME_COLS,
	parameter int frameRows = `FRAME_ROWS
) (
	input logic clk,
	input logic resetN,
	output gamePkg::coord_t pixelX,
	output gamePkg::coord_t pixelY,
	output logic startOfFrame
);

	localparam gamePkg::coord_t LAST_COL = gamePkg::coord_t'(frameCols - 1);
	localparam gamePkg::coord_t LAST_ROW = gamePkg::coord_t'(frameRows - 1);

	gamePkg::coord_t colCount;
	gamePkg::coord_t rowCount;

	// column runs every cycle, row steps on column wrap
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			colCount <= '0;
			rowCount <= '0;
		end else if (colCount == LAST_COL) begin
			colCount <= '0;
			if (rowCount == LAST_ROW)
				rowCount <= '0;
			else
				rowCount <= rowCount + 11'sd1;
		end else begin
			colCount <= colCount + 11'sd1;
		end
	end

	assign pixelX = colCount;
	assign pixelY = rowCount;

	// top-left pixel of the raster marks the new frame
	assign startOfFrame = (colCount == '0) && (rowCount == '0);

	// frame pulse is a single cycle wide
	framePulseSingle: assert property (
		@(posedge clk) disable iff (!resetN)
		startOfFrame |=> !startOfFrame
	);

endmodule

//--- logic/randomSource.sv
`timescale 1ns/1ps

module randomSource (
	input logic clk,
	input logic resetN,
	output logic [10:0] rng
);

	localparam logic [10:0] SEED = 11'h5a5;

	logic [10:0] lfsrState;
	logic feedback;

	// taps for x^11 + x^9 + 1, period 2047
	assign feedback = lfsrState[10] ^ lfsrState[8];

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			lfsrState <= SEED;
		else
			lfsrState <= {lfsrState[9:0], feedback};
	end

	assign rng = lfsrState;

	// all-zero state would lock up the shifter
	lfsrNeverZero: assert property (
		@(posedge clk) disable iff (!resetN)
		lfsrState != '0
	);

endmodule

//--- logic/dragonMover.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module dragonMover (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic pause,
	input logic [10:0] rng,
	input logic hit,
	output gamePkg::coord_t dragonX,
	output gamePkg::coord_t dragonY,
	output logic dragonActive
);

	localparam gamePkg::speed_t X_SPEED = gamePkg::speed_t'(`DRAGON_X_SPEED);
	localparam gamePkg::speed_t Y_SPEED = gamePkg::speed_t'(`DRAGON_Y_SPEED);
	localparam gamePkg::fixed_t START_X =
		gamePkg::fixed_t'(`DRAGON_START_X * (1 << gamePkg::FRAC_BITS));
	localparam gamePkg::fixed_t START_Y =
		gamePkg::fixed_t'(`DRAGON_START_Y * (1 << gamePkg::FRAC_BITS));
	localparam logic [12:0] FIRST_WAIT = 13'(`DRAGON_FIRST_WAIT);

	gamePkg::fixed_t posX;
	gamePkg::fixed_t posY;
	gamePkg::speed_t ySpeed;
	gamePkg::speed_t nextYSpeed;
	logic [12:0] waitCount;
	logic [12:0] waitReload;
	logic rngFlip;

	assign dragonX = gamePkg::fixedToCoord(posX);
	assign dragonY = gamePkg::fixedToCoord(posY);

	// random reversal window, strictly between 300 and 600
	assign rngFlip = (rng > 11'd300) && (rng < 11'd600);

	// next wait is twice rng plus the base wait
	assign waitReload = {1'b0, rng, 1'b0} + FIRST_WAIT;

	// band edges force the direction, otherwise maybe flip
	always_comb begin
		if (dragonY < `DRAGON_TOP_ROW)
			nextYSpeed = Y_SPEED;
		else if (dragonY > `DRAGON_BOTTOM_ROW)
			nextYSpeed = -Y_SPEED;
		else if (rngFlip)
			nextYSpeed = -ySpeed;
		else
			nextYSpeed = ySpeed;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			dragonActive <= 1'b0;
			waitCount <= FIRST_WAIT;
			posX <= START_X;
			posY <= START_Y;
			ySpeed <= Y_SPEED;
		end else if (hit) begin
			dragonActive <= 1'b0;
		end else if (startOfFrame) begin
			if (!dragonActive) begin
				// parked at the entry point while the wait runs
				posX <= START_X;
				posY <= START_Y;
				ySpeed <= Y_SPEED;
				if (waitCount == '0) begin
					dragonActive <= 1'b1;
					waitCount <= waitReload;
				end else begin
					waitCount <= waitCount - 13'd1;
				end
			end else if (dragonX < `DRAGON_EXIT_X) begin
				// off the left edge, back to waiting
				dragonActive <= 1'b0;
			end else if (!pause) begin
				posX <= posX + gamePkg::speedToFixed(X_SPEED);
				posY <= posY + gamePkg::speedToFixed(nextYSpeed);
				ySpeed <= nextYSpeed;
			end
		end
	end

	// one frame of overshoot is at most about one pixel past the band
	dragonInBand: assert property (
		@(posedge clk) disable iff (!resetN)
		dragonActive |-> (dragonY >= (`DRAGON_TOP_ROW - 2)) &&
			(dragonY <= (`DRAGON_BOTTOM_ROW + 2))
	);

endmodule

//--- logic/shotMover.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module shotMover (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic fire,
	input gamePkg::coord_t aimY,
	input logic pause,
	input logic hit,
	output gamePkg::coord_t shotX,
	output gamePkg::coord_t shotY,
	output logic shotActive
);

	localparam gamePkg::speed_t SHOT_SPEED = gamePkg::speed_t'(`SHOT_SPEED);
	localparam gamePkg::fixed_t START_X =
		gamePkg::fixed_t'(`SHOT_START_X * (1 << gamePkg::FRAC_BITS));

	gamePkg::fixed_t posX;
	gamePkg::coord_t rowY;

	assign shotX = gamePkg::fixedToCoord(posX);
	assign shotY = rowY;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			shotActive <= 1'b0;
			posX <= START_X;
			rowY <= '0;
		end else if (hit) begin
			shotActive <= 1'b0;
		end else if (startOfFrame) begin
			if (!shotActive) begin
				// launch from the left column at the aimed row
				if (fire) begin
					shotActive <= 1'b1;
					posX <= START_X;
					rowY <= aimY;
				end
			end else if (shotX > `SCREEN_RIGHT) begin
				shotActive <= 1'b0;
			end else if (!pause) begin
				posX <= posX + gamePkg::speedToFixed(SHOT_SPEED);
			end
		end
	end

endmodule

//--- logic/spriteDraw.sv
`timescale 1ns/1ps

module spriteDraw #(
	parameter int boxW = 8,
	parameter int boxH = 8
) (
	input logic clk,
	input logic resetN,
	input gamePkg::coord_t pixelX,
	input gamePkg::coord_t pixelY,
	input gamePkg::coord_t objX,
	input gamePkg::coord_t objY,
	input logic objActive,
	output logic draw
);

	int objRight;
	int objBottom;
	logic insideBox;

	// edges in int so a box near the top of the range cannot wrap
	assign objRight = int'(objX) + boxW;
	assign objBottom = int'(objY) + boxH;

	// half-open box, left and top edges included
	assign insideBox = objActive &&
		(pixelX >= objX) && (pixelX < objRight) &&
		(pixelY >= objY) && (pixelY < objBottom);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			draw <= 1'b0;
		else
			draw <= insideBox;
	end

endmodule

//--- logic/collisionDetect.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module collisionDetect (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input gamePkg::coord_t dragonX,
	input gamePkg::coord_t dragonY,
	input logic dragonActive,
	input gamePkg::coord_t shotX,
	input gamePkg::coord_t shotY,
	input logic shotActive,
	output logic hit,
	output logic [15:0] hitCount
);

	logic overlapX;
	logic overlapY;
	logic overlap;

	// two half-open ranges overlap when each starts before the other ends
	assign overlapX = (int'(dragonX) < int'(shotX) + `SHOT_W) &&
		(int'(shotX) < int'(dragonX) + `DRAGON_W);
	assign overlapY = (int'(dragonY) < int'(shotY) + `SHOT_H) &&
		(int'(shotY) < int'(dragonY) + `DRAGON_H);
	assign overlap = dragonActive && shotActive && overlapX && overlapY;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hit <= 1'b0;
			hitCount <= '0;
		end else begin
			hit <= startOfFrame && overlap;
			if (startOfFrame && overlap)
				hitCount <= hitCount + 16'd1;
		end
	end

	hitOneCycle: assert property (
		@(posedge clk) disable iff (!resetN)
		hit |=> !hit
	);

endmodule

//--- logic/dragonScene.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module dragonScene #(
	parameter int frameCols = `FRAME_COLS,
	parameter int frameRows = `FRAME_ROWS
) (
	input logic clk,
	input logic resetN,
	input logic fire,
	input gamePkg::coord_t aimY,
	input logic pause,
	output gamePkg::coord_t pixelX,
	output gamePkg::coord_t pixelY,
	output logic startOfFrame,
	output gamePkg::coord_t dragonX,
	output gamePkg::coord_t dragonY,
	output logic dragonActive,
	output gamePkg::coord_t shotX,
	output gamePkg::coord_t shotY,
	output logic shotActive,
	output logic drawDragon,
	output logic drawShot,
	output logic hit,
	output logic [15:0] hitCount
);

	logic [10:0] rng;

	frameTimer #(.frameCols(frameCols), .frameRows(frameRows)) frameTimer_inst (
		.clk(clk), .resetN(resetN),
		.pixelX(pixelX), .pixelY(pixelY), .startOfFrame(startOfFrame)
	);

	randomSource randomSource_inst (.clk(clk), .resetN(resetN), .rng(rng));

	dragonMover dragonMover_inst (
		.clk(clk), .resetN(resetN), .startOfFrame(startOfFrame), .pause(pause),
		.rng(rng), .hit(hit),
		.dragonX(dragonX), .dragonY(dragonY), .dragonActive(dragonActive)
	);

	shotMover shotMover_inst (
		.clk(clk), .resetN(resetN), .startOfFrame(startOfFrame), .fire(fire),
		.aimY(aimY), .pause(pause), .hit(hit),
		.shotX(shotX), .shotY(shotY), .shotActive(shotActive)
	);

	collisionDetect collisionDetect_inst (
		.clk(clk), .resetN(resetN), .startOfFrame(startOfFrame),
		.dragonX(dragonX), .dragonY(dragonY), .dragonActive(dragonActive),
		.shotX(shotX), .shotY(shotY), .shotActive(shotActive),
		.hit(hit), .hitCount(hitCount)
	);

	// one draw request per object box
	spriteDraw #(.boxW(`DRAGON_W), .boxH(`DRAGON_H)) dragonDraw_inst (
		.clk(clk), .resetN(resetN), .pixelX(pixelX), .pixelY(pixelY),
		.objX(dragonX), .objY(dragonY), .objActive(dragonActive), .draw(drawDragon)
	);

	spriteDraw #(.boxW(`SHOT_W), .boxH(`SHOT_H)) shotDraw_inst (
		.clk(clk), .resetN(resetN), .pixelX(pixelX), .pixelY(pixelY),
		.objX(shotX), .objY(shotY), .objActive(shotActive), .draw(drawShot)
	);

endmodule

//--- dv/dragonSceneTb.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module dragonSceneTb;

	localparam int COLS = 40;
	localparam int ROWS = 20;
	localparam int CYCLES_PER_FRAME = COLS * ROWS;
	localparam int RUN_FRAMES = 360;
	localparam int TIMEOUT_CYCLES = 400 * CYCLES_PER_FRAME;
	localparam int SHOT_STEP = `SHOT_SPEED / 64;

	logic clk;
	logic resetN;
	logic fire;
	gamePkg::coord_t aimY;
	logic pause;
	gamePkg::coord_t pixelX;
	gamePkg::coord_t pixelY;
	logic startOfFrame;
	gamePkg::coord_t dragonX;
	gamePkg::coord_t dragonY;
	logic dragonActive;
	gamePkg::coord_t shotX;
	gamePkg::coord_t shotY;
	logic shotActive;
	logic drawDragon;
	logic drawShot;
	logic hit;
	logic [15:0] hitCount;

	integer seed;
	logic [31:0] rndWord;
	int pulseCount;
	int errorCount;
	int expectedHits;
	int cycleCount;
	int expCol;
	int expRow;
	bit primed;
	bit entered;

	// state seen at the previous falling edge
	logic prevSof;
	logic prevPause;
	logic prevFire;
	logic prevHit;
	gamePkg::coord_t prevAimY;
	gamePkg::coord_t prevPixelX;
	gamePkg::coord_t prevPixelY;
	gamePkg::coord_t prevDragonX;
	gamePkg::coord_t prevDragonY;
	logic prevDragonActive;
	gamePkg::coord_t prevShotX;
	gamePkg::coord_t prevShotY;
	logic prevShotActive;

	dragonScene #(.frameCols(COLS), .frameRows(ROWS)) dragonScene_inst (
		.clk(clk), .resetN(resetN), .fire(fire), .aimY(aimY), .pause(pause),
		.pixelX(pixelX), .pixelY(pixelY), .startOfFrame(startOfFrame),
		.dragonX(dragonX), .dragonY(dragonY), .dragonActive(dragonActive),
		.shotX(shotX), .shotY(shotY), .shotActive(shotActive),
		.drawDragon(drawDragon), .drawShot(drawShot), .hit(hit), .hitCount(hitCount)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic reportMismatch(input string name, input int got, input int want);
		errorCount++;
		$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, want);
	endtask

	task automatic reportProblem(input string what);
		errorCount++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	task automatic printSummary();
		$display("frames %0d, hits %0d, errors %0d", pulseCount, expectedHits, errorCount);
		if (errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
	endtask

	// half-open range test on both axes
	function automatic bit boxOverlap(input int ax, input int ay, input int aw, input int ah,
			input int bx, input int by, input int bw, input int bh);
		return (ax < bx + bw) && (bx < ax + aw) && (ay < by + bh) && (by < ay + ah);
	endfunction

	function automatic bit pixelInBox(input int px, input int py, input int ox, input int oy,
			input int w, input int h);
		return (px >= ox) && (px < ox + w) && (py >= oy) && (py < oy + h);
	endfunction

	function automatic bit isPauseFrame(input int frame);
		return ((frame >= 40) && (frame < 44)) || ((frame >= 200) && (frame < 203));
	endfunction

	// outputs settle after the rising edge, so sample on the falling one
	always @(negedge clk) begin : sampleAndCheck
		bit wantHit;
		bit wantDraw;
		bit wantSof;
		// raster position counted from reset, top-left pixel opens a frame
		if (!resetN) begin
			expCol = 0;
			expRow = 0;
		end else begin
			wantSof = (expCol == 0) && (expRow == 0);
			assert (pixelX == expCol) else reportMismatch("pixelX", pixelX, expCol);
			assert (pixelY == expRow) else reportMismatch("pixelY", pixelY, expRow);
			assert (startOfFrame == wantSof)
			else reportMismatch("startOfFrame", startOfFrame, wantSof);
			if (expCol == COLS - 1) begin
				expCol = 0;
				expRow = (expRow == ROWS - 1) ? 0 : expRow + 1;
			end else begin
				expCol++;
			end
		end
		if (resetN && primed) begin
			if (!entered)
				assert (dragonActive == (pulseCount > `DRAGON_FIRST_WAIT))
				else reportMismatch("dragonActive", dragonActive,
					pulseCount > `DRAGON_FIRST_WAIT);
			if (dragonActive && !prevDragonActive) begin
				assert (dragonX == `DRAGON_START_X)
				else reportMismatch("dragonX", dragonX, `DRAGON_START_X);
				assert (dragonY == `DRAGON_START_Y)
				else reportMismatch("dragonY", dragonY, `DRAGON_START_Y);
			end
			if (dragonActive && prevDragonActive)
				assert (dragonX <= prevDragonX) else reportProblem("dragonX moved right");
			if (dragonActive)
				assert ((dragonY >= `DRAGON_TOP_ROW - 2) && (dragonY <= `DRAGON_BOTTOM_ROW + 2))
				else reportProblem("dragonY left the bounce band");
			if (prevSof && prevPause && prevDragonActive) begin
				assert (dragonX == prevDragonX)
				else reportMismatch("dragonX", dragonX, prevDragonX);
				assert (dragonY == prevDragonY)
				else reportMismatch("dragonY", dragonY, prevDragonY);
			end

			// shot launch and travel
			if (prevSof && !prevShotActive) begin
				assert (shotActive == prevFire)
				else reportMismatch("shotActive", shotActive, prevFire);
				if (prevFire) begin
					assert (shotX == `SHOT_START_X)
					else reportMismatch("shotX", shotX, `SHOT_START_X);
					assert (shotY == prevAimY) else reportMismatch("shotY", shotY, prevAimY);
				end
			end
			if (prevSof && prevShotActive) begin
				if (prevShotX > `SCREEN_RIGHT) begin
					assert (!shotActive) else reportProblem("shot did not retire off screen");
				end else begin
					assert (shotActive) else reportProblem("shot retired too early");
					assert (shotX == prevShotX + (prevPause ? 0 : SHOT_STEP))
					else reportMismatch("shotX", shotX, prevShotX + (prevPause ? 0 : SHOT_STEP));
				end
			end

			// collision from the boxes seen at the frame pulse
			wantHit = prevSof && prevDragonActive && prevShotActive &&
				boxOverlap(prevDragonX, prevDragonY, `DRAGON_W, `DRAGON_H,
					prevShotX, prevShotY, `SHOT_W, `SHOT_H);
			if (wantHit)
				expectedHits++;
			assert (hit == wantHit) else reportMismatch("hit", hit, wantHit);
			assert (hitCount == expectedHits)
			else reportMismatch("hitCount", hitCount, expectedHits);
			if (prevHit)
				assert (!dragonActive && !shotActive)
				else reportProblem("objects still active after a hit");

			// draw requests lag the pixel by one cycle
			wantDraw = prevDragonActive && pixelInBox(prevPixelX, prevPixelY,
				prevDragonX, prevDragonY, `DRAGON_W, `DRAGON_H);
			assert (drawDragon == wantDraw) else reportMismatch("drawDragon", drawDragon, wantDraw);
			wantDraw = prevShotActive && pixelInBox(prevPixelX, prevPixelY,
				prevShotX, prevShotY, `SHOT_W, `SHOT_H);
			assert (drawShot == wantDraw) else reportMismatch("drawShot", drawShot, wantDraw);
		end
		entered = entered || (resetN && dragonActive);
		primed = resetN;
		prevSof = startOfFrame;
		prevPause = pause;
		prevFire = fire;
		prevHit = hit;
		prevAimY = aimY;
		prevPixelX = pixelX;
		prevPixelY = pixelY;
		prevDragonX = dragonX;
		prevDragonY = dragonY;
		prevDragonActive = dragonActive;
		prevShotX = shotX;
		prevShotY = shotY;
		prevShotActive = shotActive;
		if (resetN && startOfFrame)
			pulseCount++;
	end

	initial begin
		seed = 32'h52c5ce63;
		resetN = 1'b0;
		fire = 1'b0;
		aimY = '0;
		pause = 1'b0;
		repeat (4) @(posedge clk);
		#1 resetN = 1'b1;
		while (pulseCount < RUN_FRAMES) begin
			@(posedge clk);
			#1;
			rndWord = $random(seed);
			fire = (rndWord[17:16] == 2'b00);
			// low rows reach the visible raster, the rest aim near the dragon
			if (rndWord[0])
				aimY = gamePkg::coord_t'(rndWord[4:1]);
			else
				aimY = dragonY + gamePkg::coord_t'(rndWord[13:8] % 60) - 11'sd8;
			pause = isPauseFrame(pulseCount);
		end
		repeat (2) @(posedge clk);
		printSummary();
		$finish;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycleCount++;
		end
		reportProblem("run did not finish within the cycle limit");
		printSummary();
		$finish;
	end

endmodule

//--- all.f
+incdir+include
logic/gamePkg.sv
logic/frameTimer.sv
logic/randomSource.sv
logic/dragonMover.sv
logic/shotMover.sv
logic/spriteDraw.sv
logic/collisionDetect.sv
logic/dragonScene.sv
dv/dragonSceneTb.sv

//--- Bender.yml
package:
  name: dragon_scene

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/gamePkg.sv
      - logic/frameTimer.sv
      - logic/randomSource.sv
      - logic/dragonMover.sv
      - logic/shotMover.sv
      - logic/spriteDraw.sv
      - logic/collisionDetect.sv
      - logic/dragonScene.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/dragonSceneTb.sv
